/* Makefile */
# Verilator simulation of the read address generator

VERILATOR ?= verilator
TOP       ?= raddr_gen_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/raddr_gen_chk.sv */
// port checker for the read address generator: end-of-line pulse, back-pressure, known address
module raddr_gen_chk (
    input  logic              SYS_CLK,
    input  logic              SYS_NRST,
    input  logic              reg_array_full_i,
    input  logic              raddr_vld_o,
    input  raddr_pkg::raddr_t raddr_o,
    input  logic              line_end_o
);

    // end of line is a single pulse
    line_end_pulse: assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
        line_end_o |=> !line_end_o)
        else $error("line_end_o stayed high for more than one cycle");

    // a full register array blocks the next address
    full_blocks_vld: assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
        reg_array_full_i |=> !raddr_vld_o)
        else $error("raddr_vld_o high in the cycle after reg_array_full_i");

    addr_known: assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
        raddr_vld_o |-> !$isunknown(raddr_o))
        else $error("raddr_o unknown while raddr_vld_o is high");

endmodule

bind raddr_gen_top raddr_gen_chk raddr_gen_chk_i (
    .SYS_CLK          (SYS_CLK),
    .SYS_NRST         (SYS_NRST),
    .reg_array_full_i (reg_array_full_i),
    .raddr_vld_o      (raddr_vld_o),
    .raddr_o          (raddr_o),
    .line_end_o       (line_end_o)
);

/* dv/raddr_gen_tb.sv */
// read address generator testbench with clock, reset, stimulus, LFSR, reference model, compare and report
module raddr_gen_tb;
    import raddr_pkg::*;

    localparam int STRIP_TIMEOUT = 1000;    // cycles per strip

    typedef struct packed {
        logic [BANK_W-1:0]   bank;
        logic [RADDR_AW-1:0] word;
        logic                pad;
        logic [SLOT_W-1:0]   slot;
        logic                last;
    } exp_t;

    logic                SYS_CLK;
    logic                SYS_NRST;
    logic                frame_sop_i;
    logic                line_start_i;
    logic [PIX_W-1:0]    pic_size_i;
    logic                padding_i;
    logic [RADDR_AW-1:0] wraddr_start_i;
    logic                reg_array_full_i = 1'b0;
    logic                raddr_vld_o;
    raddr_t              raddr_o;
    logic                pad_o;
    logic [SLOT_W-1:0]   regnum_sel_o;
    logic                line_end_o;

    exp_t        exp_q[$];                  // expected points of the running strip
    exp_t        cur_exp;
    logic [15:0] lfsr_state = 16'd33163;
    logic        bp_en = 1'b0;
    logic        last_delivered = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          rx_count = 0;
    int          pad_count = 0;
    int          line_end_cnt = 0;

    raddr_gen_top raddr_gen_top_i (
        .SYS_CLK          (SYS_CLK),
        .SYS_NRST         (SYS_NRST),
        .frame_sop_i      (frame_sop_i),
        .line_start_i     (line_start_i),
        .pic_size_i       (pic_size_i),
        .padding_i        (padding_i),
        .wraddr_start_i   (wraddr_start_i),
        .reg_array_full_i (reg_array_full_i),
        .raddr_vld_o      (raddr_vld_o),
        .raddr_o          (raddr_o),
        .pad_o            (pad_o),
        .regnum_sel_o     (regnum_sel_o),
        .line_end_o       (line_end_o)
    );

    initial begin
        SYS_CLK = 1'b0;
        forever #10 SYS_CLK = ~SYS_CLK;
    end

    // ==========================================================
    // reference model
    // ==========================================================
    function automatic int strip_points(input int size, input int pad);
        return 9 + 3 * (size + 2 * pad - 3);   // full window then 3 per move
    endfunction

    function automatic exp_t expected_point(input int size, input int pad, input int idx,
                                            input int base_addr, input int n);
        int   k;
        int   dx;
        int   dy;
        int   x;
        int   y;
        exp_t e;
        if (n < 9) begin
            k  = 0;
            dy = n / 3;
            dx = n % 3;
        end else begin
            k  = 1 + (n - 9) / 3;              // only the new bottom row
            dy = 2;
            dx = (n - 9) % 3;
        end
        x      = idx - pad + dx;
        y      = k - pad + dy;
        e.bank = BANK_W'(((x % NUM_BANKS) + NUM_BANKS) % NUM_BANKS);
        e.word = RADDR_AW'(base_addr + y);
        e.pad  = (x < 0) || (y < 0) || (x >= size) || (y >= size);
        e.slot = SLOT_W'(((k + dy) % 3) * 3 + dx);
        e.last = (n == strip_points(size, pad) - 1);
        return e;
    endfunction

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("MISMATCH %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic confirm(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR %s", what);
            errors++;
        end
    endtask

    // random register array full level with one LFSR step per bit
    always @(negedge SYS_CLK) begin
        if (bp_en) begin
            reg_array_full_i <= lfsr_state[0];
            lfsr_state       <= galois_step(lfsr_state);
        end else begin
            reg_array_full_i <= 1'b0;
        end
    end

    // ==========================================================
    // compare process sampling between rising edges
    // ==========================================================
    always @(negedge SYS_CLK) begin
        if (SYS_NRST) begin
            compare_value("line_end_o", line_end_o, last_delivered);
            if (line_end_o) begin
                line_end_cnt++;
            end
            confirm(!(raddr_vld_o && reg_array_full_i),
                    "raddr_vld_o rose right after reg_array_full_i was high");
            last_delivered = 1'b0;
            if (raddr_vld_o) begin
                rx_count++;
                confirm(exp_q.size() != 0, "raddr_vld_o high with no point left in the strip");
                if (exp_q.size() != 0) begin
                    cur_exp = exp_q.pop_front();
                    compare_value("raddr_o.bank", raddr_o.bank, cur_exp.bank);
                    compare_value("raddr_o.word", raddr_o.word, cur_exp.word);
                    compare_value("pad_o", pad_o, cur_exp.pad);
                    compare_value("regnum_sel_o", regnum_sel_o, cur_exp.slot);
                    last_delivered = cur_exp.last;
                    if (pad_o) begin
                        pad_count++;
                    end
                end
            end
        end
    end

    // ==========================================================
    // stimulus
    // ==========================================================
    task automatic clear_strip_index();
        @(negedge SYS_CLK);
        frame_sop_i = 1'b1;
        @(negedge SYS_CLK);
        frame_sop_i = 1'b0;
    endtask

    task automatic send_line_start();
        @(negedge SYS_CLK);
        line_start_i = 1'b1;
        @(negedge SYS_CLK);
        line_start_i = 1'b0;
    endtask

    task automatic start_strip(input int size, input int pad, input int idx, input int base);
        @(negedge SYS_CLK);
        exp_q.delete();
        rx_count  = 0;
        pad_count = 0;
        for (int n = 0; n < strip_points(size, pad); n++) begin
            exp_q.push_back(expected_point(size, pad, idx, base, n));
        end
        pic_size_i     = PIX_W'(size);       // config held for the whole strip
        padding_i      = pad[0];
        wraddr_start_i = RADDR_AW'(base);
        send_line_start();
    endtask

    task automatic wait_strip_end(input int expected_points);
        int start_cnt;
        int cycles;
        start_cnt = line_end_cnt;
        cycles    = 0;
        while (line_end_cnt == start_cnt && cycles < STRIP_TIMEOUT) begin
            @(posedge SYS_CLK);
            cycles++;
        end
        confirm(line_end_cnt != start_cnt,
                $sformatf("timeout, no line_end_o within %0d cycles", STRIP_TIMEOUT));
        compare_value("point count", rx_count, expected_points);
        confirm(exp_q.size() == 0, "strip ended with points still expected");
    endtask

    task automatic run_strip(input int size, input int pad, input int idx, input int base);
        start_strip(size, pad, idx, base);
        wait_strip_end(strip_points(size, pad));
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    initial begin
        int err_before;
        SYS_NRST       = 1'b0;
        frame_sop_i    = 1'b0;
        line_start_i   = 1'b0;
        pic_size_i     = PIX_W'(8);
        padding_i      = 1'b0;
        wraddr_start_i = '0;
        repeat (16) @(posedge SYS_CLK);
        @(negedge SYS_CLK);
        SYS_NRST = 1'b1;

        err_before = errors;
        clear_strip_index();
        run_strip(8, 0, 0, 0);
        confirm(pad_count == 0, "pad flag raised inside the picture");
        finish_test("no padding, strip 0", err_before);

        err_before = errors;
        clear_strip_index();
        run_strip(8, 1, 0, 'h040);
        finish_test("padding 1, edge pads", err_before);

        err_before = errors;
        clear_strip_index();
        @(posedge SYS_CLK);
        bp_en = 1'b1;
        run_strip(8, 1, 0, 'h3F8);           // word wraps past the top
        bp_en = 1'b0;
        finish_test("random back-pressure", err_before);

        err_before = errors;
        clear_strip_index();
        for (int s = 0; s < 4; s++) begin
            run_strip(8, 0, s, 'h100);
        end
        finish_test("four strips after frame start", err_before);

        err_before = errors;
        clear_strip_index();
        run_strip(8, 0, 0, 0);
        finish_test("frame start resets strip index", err_before);

        err_before = errors;
        clear_strip_index();
        start_strip(8, 0, 0, 0);
        repeat (3) @(negedge SYS_CLK);
        send_line_start();                   // strip still busy
        wait_strip_end(strip_points(8, 0));
        run_strip(8, 0, 1, 0);
        finish_test("line start while busy", err_before);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* project.f */
source/raddr_pkg.sv
source/window_scanner.sv
source/point_fifo.sv
source/addr_mapper.sv
source/raddr_gen_top.sv
dv/raddr_gen_chk.sv
dv/raddr_gen_tb.sv

/* source/addr_mapper.sv */
// address mapper: pop control, bounds check, bank/word mapping, slot select, end-of-line pulse
module addr_mapper (
    input  logic                           SYS_CLK,
    input  logic                           SYS_NRST,
    input  logic                           empty_i,
    input  raddr_pkg::point_t              point_i,
    input  logic                           reg_array_full_i,  // stalls pops
    input  logic [raddr_pkg::PIX_W-1:0]    pic_size_i,
    input  logic [raddr_pkg::RADDR_AW-1:0] wraddr_start_i,
    output logic                           pop_o,
    output logic                           raddr_vld_o,
    output raddr_pkg::raddr_t              raddr_o,
    output logic                           pad_o,
    output logic [raddr_pkg::SLOT_W-1:0]   regnum_sel_o,
    output logic                           line_end_o
);
    import raddr_pkg::*;

    logic signed [COORD_W-1:0] size_s;
    logic                      out_x;
    logic                      out_y;
    raddr_t                    raddr_d;
    logic                      last_q;     // last point is on the outputs

    assign pop_o  = !empty_i && !reg_array_full_i;
    assign size_s = COORD_W'(pic_size_i);

    // ==========================================================
    // bounds check and address mapping
    // ==========================================================
    // outside the picture -> register array loads zero
    assign out_x = point_i.pix_x[COORD_W-1] || ($signed(point_i.pix_x) >= size_s);
    assign out_y = point_i.pix_y[COORD_W-1] || ($signed(point_i.pix_y) >= size_s);

    always_comb begin
        raddr_d.bank = point_i.pix_x[BANK_W-1:0];  // column mod 4, -1 maps to 3
        // kept even for padded rows, the pad flag masks it
        raddr_d.word = wraddr_start_i + RADDR_AW'($signed(point_i.pix_y));
    end

    // ==========================================================
    // registered outputs
    // ==========================================================
    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            raddr_vld_o <= 1'b0;
            last_q      <= 1'b0;
            line_end_o  <= 1'b0;
            pad_o       <= 1'b0;
        end else begin
            raddr_vld_o <= pop_o;
            last_q      <= pop_o && point_i.last;
            line_end_o  <= last_q;          // one cycle after the last address
            if (pop_o) begin
                pad_o <= out_x || out_y;
            end
        end
    end

    always_ff @(posedge SYS_CLK) begin
        if (pop_o) begin
            raddr_o      <= raddr_d;
            regnum_sel_o <= point_i.slot;
        end
    end

endmodule

/* source/point_fifo.sv */
// point FIFO: register array storage, read/write pointers, occupancy count, full/empty levels
module point_fifo #(
    parameter int FIFO_DEPTH = 4            // power of two, 2 or more
) (
    input  logic              SYS_CLK,
    input  logic              SYS_NRST,
    input  logic              push_i,
    input  raddr_pkg::point_t point_i,
    input  logic              pop_i,
    output raddr_pkg::point_t point_o,      // head, straight from storage
    output logic              full_o,
    output logic              empty_o
);
    import raddr_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    point_t           mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;               // one extra bit for full
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o  = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty_o = (count == '0);
    assign point_o = mem[rd_ptr];

    always_ff @(posedge SYS_CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= point_i;
        end
    end

    // ==========================================================
    // pointers and occupancy
    // ==========================================================
    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/raddr_gen_top.sv */
// read address generator top: window scanner, point FIFO and address mapper
module raddr_gen_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                           SYS_CLK,
    input  logic                           SYS_NRST,
    input  logic                           frame_sop_i,
    input  logic                           line_start_i,
    input  logic [raddr_pkg::PIX_W-1:0]    pic_size_i,
    input  logic                           padding_i,
    input  logic [raddr_pkg::RADDR_AW-1:0] wraddr_start_i,
    input  logic                           reg_array_full_i,
    output logic                           raddr_vld_o,
    output raddr_pkg::raddr_t              raddr_o,
    output logic                           pad_o,
    output logic [raddr_pkg::SLOT_W-1:0]   regnum_sel_o,
    output logic                           line_end_o
);
    import raddr_pkg::*;

    point_t push_point;                     // scanner -> fifo
    point_t head_point;                     // fifo -> mapper
    logic   push;
    logic   pop;
    logic   fifo_full;
    logic   fifo_empty;

    window_scanner window_scanner_i (
        .SYS_CLK      (SYS_CLK),
        .SYS_NRST     (SYS_NRST),
        .frame_sop_i  (frame_sop_i),
        .line_start_i (line_start_i),
        .pic_size_i   (pic_size_i),
        .padding_i    (padding_i),
        .fifo_full_i  (fifo_full),
        .push_o       (push),
        .point_o      (push_point)
    );

    point_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) point_fifo_i (
        .SYS_CLK  (SYS_CLK),
        .SYS_NRST (SYS_NRST),
        .push_i   (push),
        .point_i  (push_point),
        .pop_i    (pop),
        .point_o  (head_point),
        .full_o   (fifo_full),
        .empty_o  (fifo_empty)
    );

    addr_mapper addr_mapper_i (
        .SYS_CLK          (SYS_CLK),
        .SYS_NRST         (SYS_NRST),
        .empty_i          (fifo_empty),
        .point_i          (head_point),
        .reg_array_full_i (reg_array_full_i),
        .pic_size_i       (pic_size_i),
        .wraddr_start_i   (wraddr_start_i),
        .pop_o            (pop),
        .raddr_vld_o      (raddr_vld_o),
        .raddr_o          (raddr_o),
        .pad_o            (pad_o),
        .regnum_sel_o     (regnum_sel_o),
        .line_end_o       (line_end_o)
    );

endmodule

/* source/raddr_pkg.sv */
// package: address and pixel widths, window constants, point and read address structs
package raddr_pkg;

    // ==========================================================
    // widths
    // ==========================================================
    localparam int RADDR_AW  = 10;           // word address inside one bank
    localparam int PIX_W     = 6;            // picture size and unsigned counts
    localparam int COORD_W   = PIX_W + 2;    // signed, room for -1 and size+1

    // ==========================================================
    // window and bank constants
    // ==========================================================
    localparam int WIN_DIM   = 3;            // 3x3 kernel
    localparam int NUM_BANKS = 4;
    localparam int BANK_W    = $clog2(NUM_BANKS);
    localparam int SLOT_W    = 4;            // register array slot 0..8

    // one read point of the window, scanner to mapper
    typedef struct packed {
        logic signed [COORD_W-1:0] pix_x;
        logic signed [COORD_W-1:0] pix_y;
        logic        [SLOT_W-1:0]  slot;     // register array slot
        logic                      last;     // final point of the strip
    } point_t;

    // one SRAM read address
    typedef struct packed {
        logic [BANK_W-1:0]   bank;           // pixel column mod 4
        logic [RADDR_AW-1:0] word;
    } raddr_t;

endpackage

/* source/window_scanner.sv */
// window scanner: strip index counter, busy flag, window and step counters, point generation
module window_scanner (
    input  logic                        SYS_CLK,
    input  logic                        SYS_NRST,
    input  logic                        frame_sop_i,    // clears strip index
    input  logic                        line_start_i,   // starts one strip
    input  logic [raddr_pkg::PIX_W-1:0] pic_size_i,
    input  logic                        padding_i,
    input  logic                        fifo_full_i,
    output logic                        push_o,
    output raddr_pkg::point_t           point_o
);
    import raddr_pkg::*;

    logic [PIX_W-1:0]          strip_idx;   // line starts since frame start
    logic [PIX_W-1:0]          cur_idx;
    logic                      busy;
    logic [PIX_W-1:0]          win_k;       // window number in strip
    logic [1:0]                rot;         // win_k mod 3, row rotation
    logic [1:0]                dx;
    logic [1:0]                dy;
    logic signed [COORD_W-1:0] col_base;    // left pixel column of strip
    logic signed [COORD_W-1:0] row_top;

    logic [PIX_W:0]            num_win;
    logic                      start;
    logic                      last_win;
    logic                      win_done;
    logic                      last_pt;
    logic [2:0]                row_sum;
    logic [1:0]                row_slot;

    // ==========================================================
    // strip control
    // ==========================================================
    assign start   = line_start_i && !busy;  // ignored while busy
    assign cur_idx = frame_sop_i ? '0 : strip_idx;

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            strip_idx <= '0;
        end else if (start) begin
            strip_idx <= cur_idx + 1'b1;
        end else if (frame_sop_i) begin
            strip_idx <= '0;
        end
    end

    always_ff @(posedge SYS_CLK) begin
        if (start) begin
            col_base <= COORD_W'(cur_idx) - COORD_W'(padding_i);
        end
    end

    // W = size + 2*pad - 2
    assign num_win  = {1'b0, pic_size_i} + {padding_i, 1'b0} - (PIX_W + 1)'(WIN_DIM - 1);
    assign last_win = ({1'b0, win_k} == num_win - 1'b1);
    assign win_done = (dx == 2'(WIN_DIM - 1)) && (dy == 2'(WIN_DIM - 1));
    assign last_pt  = last_win && win_done;

    assign push_o = busy && !fifo_full_i;   // hold point while fifo full

    // ==========================================================
    // window and step counters
    // ==========================================================
    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            busy  <= 1'b0;
            win_k <= '0;
            rot   <= '0;
            dx    <= '0;
            dy    <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            win_k <= '0;
            rot   <= '0;
            dx    <= '0;
            dy    <= '0;                    // full window first
        end else if (push_o) begin
            if (last_pt) begin
                busy <= 1'b0;
            end
            if (dx == 2'(WIN_DIM - 1)) begin
                dx <= '0;
                if (win_done) begin         // move down, dy stays on bottom row
                    win_k <= win_k + 1'b1;
                    rot   <= (rot == 2'(WIN_DIM - 1)) ? '0 : rot + 1'b1;
                end else begin
                    dy <= dy + 1'b1;
                end
            end else begin
                dx <= dx + 1'b1;
            end
        end
    end

    // slot = ((k + dy) mod 3) * 3 + dx
    assign row_sum  = {1'b0, rot} + {1'b0, dy};
    assign row_slot = (row_sum >= 3'(WIN_DIM)) ? 2'(row_sum - 3'(WIN_DIM)) : row_sum[1:0];
    assign row_top  = COORD_W'(win_k) - COORD_W'(padding_i);

    always_comb begin
        point_o.pix_x = col_base + COORD_W'(dx);
        point_o.pix_y = row_top + COORD_W'(dy);
        point_o.slot  = SLOT_W'(row_slot) * SLOT_W'(WIN_DIM) + SLOT_W'(dx);
        point_o.last  = last_pt;
    end

endmodule
